//--- logic/mac_consts.svh
`ifndef MAC_CONSTS_SVH
`define MAC_CONSTS_SVH

//////////////////////////////
// Station addressing.
//////////////////////////////

`define MAC_SRC_ADDR        48'hF5DB0A3EBE79   // Our own address, also the RX filter.
`define MAC_DST_ADDR        48'hFFFFFFFFFFFF   // TX frames all go out as broadcast.

//////////////////////////////
// Framing.
//////////////////////////////

`define MAC_PREAMBLE_BYTE   8'h55
`define MAC_SFD_BYTE        8'hD5
`define MAC_MAX_DLEN        64                 // Largest payload, sets the RX buffer depth.

// Register value left behind once a good FCS has been shifted through.
`define MAC_CRC_RESIDUE     32'hDEBB20E3

`endif

//--- logic/mac_pkg.sv
package mac_pkg;

    //////////////////////////////
    // FSM encodings.
    //////////////////////////////

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PREAMBLE,
        TX_HEADER,
        TX_PAYLOAD,
        TX_FCS,
        TX_DONE
    } tx_state_t;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_HEADER,
        RX_PAYLOAD,
        RX_CHECK,
        RX_HOLD
    } rx_state_t;

    //////////////////////////////
    // CRC-32, reflected, one byte per call.
    //////////////////////////////

    function automatic logic [31:0] crc32_step(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'h000000, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
        end
        return c;
    endfunction

endpackage

//--- logic/mac_crc32.sv
`include "mac_consts.svh"

// Running FCS register. The caller complements the result itself when it
// sends the FCS; the receiver just compares against the fixed residue.
module mac_crc32 (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear,
    input  logic        en,
    input  logic [7:0]  data,
    output logic [31:0] crc,
    output logic        residue_ok
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= 32'hFFFFFFFF;
        end else if (clear) begin
            crc <= 32'hFFFFFFFF;                       // Clear wins over en.
        end else if (en) begin
            crc <= mac_pkg::crc32_step(crc, data);
        end
    end

    assign residue_ok = (crc == `MAC_CRC_RESIDUE);

endmodule

//--- logic/mac_tx_top.sv
`include "mac_consts.svh"

module mac_tx_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        fs,
    input  logic [15:0] mac_mode,
    input  logic [15:0] data_len,
    input  logic [7:0]  fifo_rxd,
    output logic        fd,
    output logic        fifo_rxen,
    output logic [7:0]  txd,
    output logic        txen
);

    mac_pkg::tx_state_t state;
    logic [15:0]  cnt;            // Byte index inside the current section.
    logic [111:0] hdr;
    logic [111:0] hdr_shift;
    logic [7:0]   hdr_byte;
    logic [31:0]  crc;
    logic [31:0]  crc_shift;
    logic [7:0]   fcs_byte;
    logic [7:0]   crc_data;
    logic         crc_clear;
    logic         crc_en;

    //////////////////////////////
    // Header and FCS byte select.
    //////////////////////////////

    assign hdr       = {`MAC_DST_ADDR, `MAC_SRC_ADDR, mac_mode};
    assign hdr_shift = hdr << {cnt[3:0], 3'b000};
    assign hdr_byte  = hdr_shift[111:104];               // MSB first on the wire.

    assign crc_shift = crc >> {cnt[1:0], 3'b000};
    assign fcs_byte  = ~crc_shift[7:0];                  // FCS goes out LSB first.

    // The CRC sees each byte in the same edge that loads it into txd.
    assign crc_clear = (state == mac_pkg::TX_IDLE);
    assign crc_en    = (state == mac_pkg::TX_HEADER) || (state == mac_pkg::TX_PAYLOAD);
    assign crc_data  = (state == mac_pkg::TX_HEADER) ? hdr_byte : fifo_rxd;

    mac_crc32 crc_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (crc_clear),
        .en         (crc_en),
        .data       (crc_data),
        .crc        (crc),
        .residue_ok ()
    );

    // Read strobe leads the FIFO data by one cycle, so it fires during the
    // last header byte and every payload byte except the final one.
    assign fifo_rxen = ((state == mac_pkg::TX_HEADER) && (cnt == 16'd13) &&
                        (data_len != 16'd0)) ||
                       ((state == mac_pkg::TX_PAYLOAD) && ((cnt + 16'd1) < data_len));

    //////////////////////////////
    // Frame sequencer.
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mac_pkg::TX_IDLE;
            cnt   <= 16'd0;
            txd   <= 8'h00;
            txen  <= 1'b0;
            fd    <= 1'b0;
        end else begin
            case (state)
                mac_pkg::TX_IDLE: begin
                    if (fs) begin
                        state <= mac_pkg::TX_PREAMBLE;
                        cnt   <= 16'd1;
                        txen  <= 1'b1;
                        txd   <= `MAC_PREAMBLE_BYTE;       // First of seven.
                    end
                end
                mac_pkg::TX_PREAMBLE: begin
                    if (cnt == 16'd7) begin
                        txd   <= `MAC_SFD_BYTE;
                        cnt   <= 16'd0;
                        state <= mac_pkg::TX_HEADER;
                    end else begin
                        txd <= `MAC_PREAMBLE_BYTE;
                        cnt <= cnt + 16'd1;
                    end
                end
                mac_pkg::TX_HEADER: begin
                    txd <= hdr_byte;
                    if (cnt == 16'd13) begin
                        cnt <= 16'd0;
                        if (data_len == 16'd0) begin
                            state <= mac_pkg::TX_FCS;
                        end else begin
                            state <= mac_pkg::TX_PAYLOAD;
                        end
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                mac_pkg::TX_PAYLOAD: begin
                    txd <= fifo_rxd;
                    if (cnt == (data_len - 16'd1)) begin
                        cnt   <= 16'd0;
                        state <= mac_pkg::TX_FCS;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                mac_pkg::TX_FCS: begin
                    txd <= fcs_byte;
                    if (cnt == 16'd3) begin
                        cnt   <= 16'd0;
                        state <= mac_pkg::TX_DONE;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                mac_pkg::TX_DONE: begin
                    txen <= 1'b0;
                    txd  <= 8'h00;
                    // fd waits one cycle behind txen, then for the host to let go of fs.
                    if (!txen && !fd) begin
                        fd <= 1'b1;
                    end else if (fd && !fs) begin
                        fd    <= 1'b0;
                        state <= mac_pkg::TX_IDLE;
                    end
                end
                default: state <= mac_pkg::TX_IDLE;
            endcase
        end
    end

    a_no_txen_with_fd: assert property (@(posedge clk) disable iff (!rst_n) !(txen && fd));

endmodule

//--- logic/mac_rx_top.sv
`include "mac_consts.svh"

module mac_rx_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  rxd,
    input  logic        rxdv,
    input  logic        rxer,
    input  logic        fd,
    input  logic        fifo_rxen,
    output logic        fs,
    output logic [15:0] mac_mode,
    output logic [15:0] data_len,
    output logic [7:0]  fifo_rxd
);

    localparam int BUF_DEPTH = `MAC_MAX_DLEN + 4;      // Payload plus the FCS bytes.
    localparam int AW        = $clog2(BUF_DEPTH);

    mac_pkg::rx_state_t state;
    logic [3:0]    hdr_cnt;
    logic [15:0]   wr_cnt;          // Saturates one past BUF_DEPTH to flag an overlong frame.
    logic [AW-1:0] rd_ptr;
    logic [47:0]   dst;
    logic [15:0]   mode_r;
    logic          err;
    logic          addr_ok;
    logic          crc_ok;
    logic          frame_ok;
    logic          crc_clear;
    logic          crc_en;
    logic          buf_we;
    logic [7:0]    frame_mem [BUF_DEPTH];

    mac_crc32 crc_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (crc_clear),
        .en         (crc_en),
        .data       (rxd),
        .crc        (),
        .residue_ok (crc_ok)
    );

    assign crc_clear = (state == mac_pkg::RX_IDLE) || (state == mac_pkg::RX_PREAMBLE);
    assign crc_en    = rxdv &&
                       ((state == mac_pkg::RX_HEADER) || (state == mac_pkg::RX_PAYLOAD));

    assign addr_ok  = (dst == `MAC_SRC_ADDR) || (dst == {48{1'b1}});
    assign frame_ok = addr_ok && crc_ok && !err &&
                      (wr_cnt >= 16'd4) && (wr_cnt <= 16'(BUF_DEPTH));

    assign buf_we = (state == mac_pkg::RX_PAYLOAD) && rxdv && (wr_cnt < 16'(BUF_DEPTH));

    //////////////////////////////
    // Parser and accept logic.
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= mac_pkg::RX_IDLE;
            hdr_cnt  <= 4'd0;
            wr_cnt   <= 16'd0;
            err      <= 1'b0;
            fs       <= 1'b0;
            mac_mode <= 16'h0000;
            data_len <= 16'h0000;
        end else begin
            case (state)
                mac_pkg::RX_IDLE: begin
                    err <= rxer;
                    if (rxdv) begin
                        state <= mac_pkg::RX_PREAMBLE;
                    end
                end
                mac_pkg::RX_PREAMBLE: begin
                    if (!rxdv) begin
                        state <= mac_pkg::RX_IDLE;
                    end else begin
                        err <= err | rxer;
                        if (rxd == `MAC_SFD_BYTE) begin
                            hdr_cnt <= 4'd0;
                            state   <= mac_pkg::RX_HEADER;
                        end
                    end
                end
                mac_pkg::RX_HEADER: begin
                    if (!rxdv) begin
                        state <= mac_pkg::RX_IDLE;          // Runt, drop it.
                    end else begin
                        err     <= err | rxer;
                        hdr_cnt <= hdr_cnt + 4'd1;
                        if (hdr_cnt == 4'd13) begin
                            wr_cnt <= 16'd0;
                            state  <= mac_pkg::RX_PAYLOAD;
                        end
                    end
                end
                mac_pkg::RX_PAYLOAD: begin
                    if (!rxdv) begin
                        state <= mac_pkg::RX_CHECK;
                    end else begin
                        err <= err | rxer;
                        if (wr_cnt <= 16'(BUF_DEPTH)) begin
                            wr_cnt <= wr_cnt + 16'd1;
                        end
                    end
                end
                mac_pkg::RX_CHECK: begin
                    if (frame_ok) begin
                        fs       <= 1'b1;
                        mac_mode <= mode_r;
                        data_len <= wr_cnt - 16'd4;
                        state    <= mac_pkg::RX_HOLD;
                    end else begin
                        state <= mac_pkg::RX_IDLE;
                    end
                end
                mac_pkg::RX_HOLD: begin
                    // Anything on the wire in here is ignored, and we only
                    // leave between frames so a late one is not cut in half.
                    if (fs && fd) begin
                        fs <= 1'b0;
                    end else if (!fs && !fd && !rxdv) begin
                        state <= mac_pkg::RX_IDLE;
                    end
                end
                default: state <= mac_pkg::RX_IDLE;
            endcase
        end
    end

    // Destination and Ethertype shift in MSB first.
    always_ff @(posedge clk) begin
        if ((state == mac_pkg::RX_HEADER) && rxdv) begin
            if (hdr_cnt < 4'd6) begin
                dst <= {dst[39:0], rxd};
            end
            if (hdr_cnt >= 4'd12) begin
                mode_r <= {mode_r[7:0], rxd};
            end
        end
    end

    //////////////////////////////
    // Frame buffer.
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (buf_we) begin
            frame_mem[wr_cnt[AW-1:0]] <= rxd;
        end
        if (fifo_rxen) begin
            fifo_rxd <= frame_mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if ((state == mac_pkg::RX_CHECK) && frame_ok) begin
            rd_ptr <= '0;
        end else if (fifo_rxen && (rd_ptr != AW'(BUF_DEPTH - 1))) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    a_no_write_while_held: assert property (@(posedge clk) disable iff (!rst_n) buf_we |-> !fs);

endmodule

//--- logic/mac.sv
module mac (
    input  logic        e_grxc,
    input  logic        e_rxdv,
    input  logic [7:0]  e_rxd,
    input  logic        e_rxer,

    output logic        e_gtxc,
    output logic        e_txen,
    output logic [7:0]  e_txd,
    output logic        e_txer,
    output logic        e_rstn,

    input  logic        rst_n,
    input  logic        fs_send,
    output logic        fd_send,
    output logic        fs_recv,
    input  logic        fd_recv,

    input  logic [15:0] mac_tx_mode,
    output logic [15:0] mac_rx_mode,
    input  logic [15:0] tx_dlen,
    output logic [15:0] rx_dlen,

    input  logic        fifo_cmd_rxen,
    output logic [7:0]  fifo_cmd_rxd,
    output logic        fifo_data_rxen,
    input  logic [7:0]  fifo_data_rxd
);

    logic rx_clk;

    //////////////////////////////
    // Pin ties.
    //////////////////////////////

    assign e_gtxc = e_grxc;          // TX clock is forwarded from the PHY RX clock.
    assign rx_clk = ~e_grxc;         // Sample RX data mid-eye on the falling edge.
    assign e_txer = 1'b0;
    assign e_rstn = rst_n;

    mac_tx_top tx_i (
        .clk       (e_gtxc),
        .rst_n     (rst_n),
        .fs        (fs_send),
        .mac_mode  (mac_tx_mode),
        .data_len  (tx_dlen),
        .fifo_rxd  (fifo_data_rxd),
        .fd        (fd_send),
        .fifo_rxen (fifo_data_rxen),
        .txd       (e_txd),
        .txen      (e_txen)
    );

    mac_rx_top rx_i (
        .clk       (rx_clk),
        .rst_n     (rst_n),
        .rxd       (e_rxd),
        .rxdv      (e_rxdv),
        .rxer      (e_rxer),
        .fd        (fd_recv),
        .fifo_rxen (fifo_cmd_rxen),
        .fs        (fs_recv),
        .mac_mode  (mac_rx_mode),
        .data_len  (rx_dlen),
        .fifo_rxd  (fifo_cmd_rxd)
    );

endmodule

//--- test/mac_tb.sv
`include "mac_consts.svh"

module mac_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          SIG_FD_SEND  = 0;
    localparam int          SIG_FS_RECV  = 1;
    localparam int          NUM_ROWS     = 10;
    localparam logic [47:0] PEER_ADDR    = 48'h001A2B3C4D5E;
    localparam logic [47:0] FOREIGN_ADDR = 48'h020000000001;

    typedef logic [7:0] bytes_t [`MAC_MAX_DLEN];

    typedef struct packed {
        logic        inject;         // Low loops the TX path back to RX.
        logic [15:0] etype;
        logic [15:0] len;
        logic [47:0] dst;
        logic        bad_fcs;
        logic        rxer;
        logic        accept;
        logic        hold;           // Keep the frame buffered through the next row.
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        e_rxdv;
    logic [7:0]  e_rxd;
    logic        e_rxer;
    logic        e_gtxc;
    logic        e_txen;
    logic [7:0]  e_txd;
    logic        e_txer;
    logic        e_rstn;
    logic        fs_send;
    logic        fd_send;
    logic        fs_recv;
    logic        fd_recv;
    logic [15:0] mac_tx_mode;
    logic [15:0] mac_rx_mode;
    logic [15:0] tx_dlen;
    logic [15:0] rx_dlen;
    logic        fifo_cmd_rxen;
    logic [7:0]  fifo_cmd_rxd;
    logic        fifo_data_rxen;
    logic [7:0]  fifo_data_rxd = 8'h00;

    logic        loop_sel;
    logic [7:0]  inj_rxd;
    logic        inj_dv;
    logic        inj_er;

    row_t        rows [NUM_ROWS];
    bytes_t      cur_payload;
    bytes_t      held_payload;
    logic [15:0] held_len;
    logic [15:0] held_mode;
    bit          held;
    logic [7:0]  frame_q [$];
    logic [7:0]  tx_cap [$];
    int          fifo_idx = 0;
    int          errors;
    int          tests_ok;
    int          tests_bad;

    mac mac_i (
        .e_grxc         (clk),
        .e_rxdv         (e_rxdv),
        .e_rxd          (e_rxd),
        .e_rxer         (e_rxer),
        .e_gtxc         (e_gtxc),
        .e_txen         (e_txen),
        .e_txd          (e_txd),
        .e_txer         (e_txer),
        .e_rstn         (e_rstn),
        .rst_n          (rst_n),
        .fs_send        (fs_send),
        .fd_send        (fd_send),
        .fs_recv        (fs_recv),
        .fd_recv        (fd_recv),
        .mac_tx_mode    (mac_tx_mode),
        .mac_rx_mode    (mac_rx_mode),
        .tx_dlen        (tx_dlen),
        .rx_dlen        (rx_dlen),
        .fifo_cmd_rxen  (fifo_cmd_rxen),
        .fifo_cmd_rxd   (fifo_cmd_rxd),
        .fifo_data_rxen (fifo_data_rxen),
        .fifo_data_rxd  (fifo_data_rxd)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    assign e_rxd  = loop_sel ? e_txd  : inj_rxd;
    assign e_rxdv = loop_sel ? e_txen : inj_dv;
    assign e_rxer = loop_sel ? e_txer : inj_er;

    // Host FIFO. Data follows the read strobe by one cycle.
    always @(posedge clk) begin
        if (!fs_send) begin
            fifo_idx <= 0;
        end else if (fifo_data_rxen) begin
            fifo_data_rxd <= cur_payload[fifo_idx];
            fifo_idx      <= fifo_idx + 1;
        end
    end

    always @(negedge clk) begin
        if (e_txen) begin
            tx_cap.push_back(e_txd);        // One entry per cycle of e_txen.
        end
    end

    //////////////////////////////
    // Frame model.
    //////////////////////////////

    // Reflected CRC-32, one bit at a time.
    function automatic logic [31:0] crc_next(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] r;
        logic        fb;
        r = crc;
        for (int k = 0; k < 8; k++) begin
            fb = r[0] ^ b[k];
            r  = {1'b0, r[31:1]} ^ (fb ? 32'hEDB88320 : 32'h00000000);
        end
        return r;
    endfunction

    task automatic build_frame(input logic [47:0] dst, input logic [47:0] src,
                               input logic [15:0] etype, input int len, input bit bad_fcs);
        logic [111:0] hdr;
        logic [31:0]  crc;
        logic [31:0]  fcs;
        logic [7:0]   b;
        frame_q.delete();
        hdr = {dst, src, etype};
        crc = 32'hFFFFFFFF;
        for (int i = 0; i < 7; i++) begin
            frame_q.push_back(`MAC_PREAMBLE_BYTE);
        end
        frame_q.push_back(`MAC_SFD_BYTE);
        for (int i = 0; i < 14 + len; i++) begin
            b = (i < 14) ? hdr[111 - 8 * i -: 8] : cur_payload[i - 14];
            frame_q.push_back(b);
            crc = crc_next(crc, b);
        end
        fcs = ~crc;
        for (int i = 0; i < 4; i++) begin
            frame_q.push_back(fcs[8 * i +: 8]);      // FCS leaves LSB first.
        end
        if (bad_fcs) begin
            frame_q[frame_q.size() - 2] = frame_q[frame_q.size() - 2] ^ 8'hFF;
        end
    endtask

    task automatic play_frame(input bit with_err);
        for (int i = 0; i < frame_q.size(); i++) begin
            @(posedge clk);
            inj_dv  <= 1'b1;
            inj_rxd <= frame_q[i];
            inj_er  <= with_err && (i == 30);
        end
        @(posedge clk);
        inj_dv  <= 1'b0;
        inj_rxd <= 8'h00;
        inj_er  <= 1'b0;
    endtask

    //////////////////////////////
    // Checks and handshakes.
    //////////////////////////////

    task automatic report_mismatch(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        errors++;
    endtask

    function automatic logic probe(input int sig);
        if (sig == SIG_FD_SEND) begin
            return fd_send;
        end
        return fs_recv;
    endfunction

    task automatic wait_level(input int sig, input logic level, input int limit,
                              input bit report, output bit ok);
        int cyc;
        cyc = 0;
        while ((probe(sig) !== level) && (cyc < limit)) begin
            @(posedge clk);
            cyc++;
        end
        ok = (probe(sig) === level);
        if (!ok && report) begin
            $display("Timeout at %0t ns: %s did not go to %0b within %0d cycles", $time,
                     (sig == SIG_FD_SEND) ? "fd_send" : "fs_recv", level, limit);
            errors++;
        end
    endtask

    task automatic read_back(input bytes_t exp, input int len);
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            fifo_cmd_rxen <= 1'b1;
            @(posedge clk);
            fifo_cmd_rxen <= 1'b0;
            if (fifo_cmd_rxd !== exp[i]) begin
                report_mismatch($sformatf("buffer byte %0d is %h, expected %h",
                                          i, fifo_cmd_rxd, exp[i]));
            end
        end
    endtask

    task automatic release_recv();
        bit ok;
        @(posedge clk);
        fd_recv <= 1'b1;
        wait_level(SIG_FS_RECV, 1'b0, 20, 1'b1, ok);
        fd_recv <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic check_rx_header(input logic [15:0] len, input logic [15:0] etype);
        if (rx_dlen !== len) begin
            report_mismatch($sformatf("rx_dlen is %0d, expected %0d", rx_dlen, len));
        end
        if (mac_rx_mode !== etype) begin
            report_mismatch($sformatf("mac_rx_mode is %h, expected %h", mac_rx_mode, etype));
        end
    endtask

    task automatic run_row(input int n);
        row_t r;
        bit   ok;
        int   errs_before;
        int   len;
        r           = rows[n];
        errs_before = errors;
        len         = int'(r.len);
        for (int i = 0; i < len; i++) begin
            cur_payload[i] = 8'($urandom());
        end
        if (!r.inject) begin
            build_frame(`MAC_DST_ADDR, `MAC_SRC_ADDR, r.etype, len, 1'b0);
            tx_cap.delete();
            @(posedge clk);
            loop_sel    <= 1'b1;
            mac_tx_mode <= r.etype;
            tx_dlen     <= r.len;
            fs_send     <= 1'b1;
            wait_level(SIG_FD_SEND, 1'b1, 200, 1'b1, ok);
            fs_send <= 1'b0;
            wait_level(SIG_FD_SEND, 1'b0, 20, 1'b1, ok);
            if (tx_cap.size() != frame_q.size()) begin
                report_mismatch($sformatf("e_txen high for %0d cycles, expected %0d",
                                          tx_cap.size(), frame_q.size()));
            end else begin
                for (int i = 0; i < frame_q.size(); i++) begin
                    if (tx_cap[i] !== frame_q[i]) begin
                        report_mismatch($sformatf("e_txd byte %0d is %h, expected %h",
                                                  i, tx_cap[i], frame_q[i]));
                    end
                end
            end
        end else begin
            build_frame(r.dst, PEER_ADDR, r.etype, len, r.bad_fcs);
            @(posedge clk);
            loop_sel <= 1'b0;
            play_frame(r.rxer);
        end
        if (held) begin
            // The buffer must still hold the earlier frame untouched.
            wait_level(SIG_FS_RECV, 1'b0, 40, 1'b0, ok);
            if (ok) begin
                report_mismatch("fs_recv fell while the host still held the buffer");
            end
            check_rx_header(held_len, held_mode);
            read_back(held_payload, int'(held_len));
            release_recv();
            held = 1'b0;
        end else if (r.accept) begin
            wait_level(SIG_FS_RECV, 1'b1, 20, 1'b1, ok);
            if (ok) begin
                check_rx_header(r.len, r.etype);
                if (r.hold) begin
                    held         = 1'b1;
                    held_payload = cur_payload;
                    held_len     = r.len;
                    held_mode    = r.etype;
                end else begin
                    read_back(cur_payload, len);
                    release_recv();
                end
            end
        end else begin
            wait_level(SIG_FS_RECV, 1'b1, 40, 1'b0, ok);
            if (ok) begin
                report_mismatch("fs_recv rose for a frame that should be dropped");
                release_recv();
            end
        end
        if (errors == errs_before) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("test %0d %s etype %h len %0d: %s", n, r.inject ? "inject" : "loopback",
                 r.etype, len, (errors == errs_before) ? "ok" : "failed");
    endtask

    //////////////////////////////
    // Test sequence.
    //////////////////////////////

    initial begin
        void'($urandom(82));
        errors        = 0;
        tests_ok      = 0;
        tests_bad     = 0;
        held          = 1'b0;
        rst_n         = 1'b0;
        fs_send       = 1'b0;
        fd_recv       = 1'b0;
        mac_tx_mode   = 16'h0000;
        tx_dlen       = 16'h0000;
        fifo_cmd_rxen = 1'b0;
        loop_sel      = 1'b1;
        inj_rxd       = 8'h00;
        inj_dv        = 1'b0;
        inj_er        = 1'b0;

        rows[0] = '{1'b0, 16'h0800, 16'd16, 48'h0, 1'b0, 1'b0, 1'b1, 1'b0};
        rows[1] = '{1'b0, 16'h88B5, 16'd1,  48'h0, 1'b0, 1'b0, 1'b1, 1'b0};
        rows[2] = '{1'b0, 16'h86DD, 16'd64, 48'h0, 1'b0, 1'b0, 1'b1, 1'b0};
        rows[3] = '{1'b1, 16'h1234, 16'd20, FOREIGN_ADDR,  1'b0, 1'b0, 1'b0, 1'b0};
        rows[4] = '{1'b1, 16'h1234, 16'd20, `MAC_SRC_ADDR, 1'b1, 1'b0, 1'b0, 1'b0};
        rows[5] = '{1'b1, 16'h1234, 16'd20, `MAC_SRC_ADDR, 1'b0, 1'b1, 1'b0, 1'b0};
        rows[6] = '{1'b1, 16'h0806, 16'd32, `MAC_SRC_ADDR, 1'b0, 1'b0, 1'b1, 1'b0};
        rows[7] = '{1'b1, 16'h0806, 16'd24, `MAC_SRC_ADDR, 1'b0, 1'b0, 1'b1, 1'b1};
        rows[8] = '{1'b1, 16'h9000, 16'd40, `MAC_DST_ADDR, 1'b0, 1'b0, 1'b0, 1'b0};
        rows[9] = '{1'b0, 16'h0801, 16'd8,  48'h0, 1'b0, 1'b0, 1'b1, 1'b0};

        repeat (8) @(posedge clk);
        if (e_rstn !== 1'b0) begin
            report_mismatch("e_rstn is not low while rst_n is low");
        end
        rst_n <= 1'b1;
        @(posedge clk);
        #1;
        if ({e_txen, fd_send, fs_recv, fifo_data_rxen} !== 4'b0000) begin
            report_mismatch("an output is not low after reset");
        end
        if ({e_rstn, e_txer} !== 2'b10) begin
            report_mismatch($sformatf("e_rstn is %b and e_txer is %b, expected 1 and 0",
                                      e_rstn, e_txer));
        end
        if (e_gtxc !== 1'b1) begin
            report_mismatch("e_gtxc is not high in the high phase of e_grxc");
        end
        @(negedge clk);
        #1;
        if (e_gtxc !== 1'b0) begin
            report_mismatch("e_gtxc is not low in the low phase of e_grxc");
        end
        if (errors == 0) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("test reset: %s", (errors == 0) ? "ok" : "failed");

        for (int n = 0; n < NUM_ROWS; n++) begin
            run_row(n);
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_ok + tests_bad, tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- mac_frame.f
+incdir+logic
logic/mac_pkg.sv
logic/mac_crc32.sv
logic/mac_tx_top.sv
logic/mac_rx_top.sv
logic/mac.sv
test/mac_tb.sv

//--- Makefile
TOP = mac_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f mac_frame.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@grep -qxF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log
